// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/mem_model.sv ====
////////////////////////////////////////
// Memory responder model
// Random grant delay, in-order read data
////////////////////////////////////////

module mem_model (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   mem_req_i,
    input  mem_bus_pkg::mem_addr_t mem_addr_i,
    output logic                   mem_gnt_o,
    output logic                   mem_rvalid_o,
    output mem_bus_pkg::mem_data_t mem_rdata_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // Accepted addresses and the cycle each one is answered
    mem_bus_pkg::mem_addr_t addr_q[$];
    int                     due_q[$];
    mem_bus_pkg::mem_addr_t rsp_addr;
    int                     cyc;
    int                     wait_left;
    int                     last_due;
    int                     due;
    logic                   fire;
    logic                   in_reset;

    initial begin
        mem_gnt_o    = 1'b0;
        mem_rvalid_o = 1'b0;
        mem_rdata_o  = '0;
        cyc          = 0;
        wait_left    = 0;
        last_due     = 0;
        rsp_addr     = '0;
    end

    always begin
        @(posedge clk_i);
        fire     = 1'b0;
        in_reset = !rst_ni;
        if (in_reset) begin
            addr_q.delete();
            due_q.delete();
            wait_left = 0;
        end else begin
            // Request taken on this edge
            if (mem_req_i && mem_gnt_o) begin
                due = cyc + 1 + int'($urandom_range(0, 4));
                // Answers stay in order, at most one per cycle
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                addr_q.push_back(mem_addr_i);
                due_q.push_back(due);
                // Grant delay of the next request, 0 leaves gnt high
                wait_left = int'($urandom_range(0, 3));
            end else if (mem_req_i && wait_left > 0) begin
                wait_left--;
            end
            if (due_q.size() > 0 && due_q[0] <= cyc) begin
                fire     = 1'b1;
                rsp_addr = addr_q.pop_front();
                void'(due_q.pop_front());
            end
        end
        cyc++;
        #2;
        mem_gnt_o    = !in_reset && (wait_left == 0);
        mem_rvalid_o = fire;
        mem_rdata_o  = fire ? ~rsp_addr : '0;
    end

endmodule

// ==== bench/tb_top.sv ====
////////////////////////////////////////
// Read stage testbench
// Directed tests against a memory model
////////////////////////////////////////

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    // Transactions sent over all tests set the cycle limit
    localparam int TOTAL_TXNS     = 85;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_TXNS + 200;
    localparam int SEED           = 32'h310ae520;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   in_valid_i;
    logic                   in_ready_o;
    stage_pkg::txn_id_t     in_id_i;
    logic                   in_walk_i;
    mem_bus_pkg::mem_addr_t in_addr_i;
    logic                   out_valid_o;
    logic                   out_ready_i;
    stage_pkg::txn_id_t     out_id_o;
    logic                   out_walk_o;
    mem_bus_pkg::mem_addr_t out_addr_o;
    mem_bus_pkg::mem_data_t out_data_o;
    logic                   mem_req_o;
    mem_bus_pkg::mem_addr_t mem_addr_o;
    logic                   mem_gnt_i;
    logic                   mem_rvalid_i;
    mem_bus_pkg::mem_data_t mem_rdata_i;

    // Expected outputs and expected request addresses
    stage_pkg::txn_t        exp_q[$];
    mem_bus_pkg::mem_addr_t req_q[$];
    stage_pkg::txn_t        out_txn;
    stage_pkg::txn_t        held_txn;
    logic                   held;
    logic                   sender_busy;
    stage_pkg::txn_id_t     next_id;
    int                     mismatch_cnt;
    int                     fault_cnt;
    int                     in_cnt;
    int                     cycle_cnt;
    // Ready mode 0 holds ready high, 1 holds it low and 2 randomizes it
    int                     ready_mode;

    memory_read_stage memory_read_stage_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_id_i      (in_id_i),
        .in_walk_i    (in_walk_i),
        .in_addr_i    (in_addr_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_id_o     (out_id_o),
        .out_walk_o   (out_walk_o),
        .out_addr_o   (out_addr_o),
        .out_data_o   (out_data_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_gnt_i    (mem_gnt_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    mem_model u_mem (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .mem_req_i    (mem_req_o),
        .mem_addr_i   (mem_addr_o),
        .mem_gnt_o    (mem_gnt_i),
        .mem_rvalid_o (mem_rvalid_i),
        .mem_rdata_o  (mem_rdata_i)
    );

    assign out_txn = {out_id_o, out_walk_o, out_addr_o, out_data_o};

    always #10 clk_i = ~clk_i;

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_txn(input stage_pkg::txn_t got, input stage_pkg::txn_t exp,
                             input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $write("Mismatch at %0t: %s id %0h walk %0b addr %h data %h", $time, what,
                   got.id, got.walk, got.addr, got.data);
            $display(", expected id %0h walk %0b addr %h data %h",
                     exp.id, exp.walk, exp.addr, exp.data);
        end
    endtask

    task automatic check_addr(input mem_bus_pkg::mem_addr_t got,
                              input mem_bus_pkg::mem_addr_t exp, input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input stage_pkg::stage_cnt_t got,
                               input stage_pkg::stage_cnt_t exp, input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Expected output keeps the fields and takes the address complement as walk data
    function automatic stage_pkg::txn_t expect_txn(input stage_pkg::txn_id_t id,
                                                   input logic walk,
                                                   input mem_bus_pkg::mem_addr_t addr);
        stage_pkg::txn_t t;
        t.id   = id;
        t.walk = walk;
        t.addr = addr;
        t.data = walk ? ~addr : '0;
        return t;
    endfunction

    ////////////////////////////////////////
    // Ready driver and monitor
    ////////////////////////////////////////

    always begin
        @(posedge clk_i);
        #2;
        case (ready_mode)
            1:       out_ready_i = 1'b0;
            2:       out_ready_i = 1'($urandom_range(0, 1));
            default: out_ready_i = 1'b1;
        endcase
    end

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            held = 1'b0;
        end else begin
            // A stalled output must not change
            if (held) begin
                check_bit(out_valid_o, 1'b1, "out_valid_o while stalled");
                check_txn(out_txn, held_txn, "stalled output");
            end
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    fault_cnt++;
                    $display("Output at %0t with no transaction outstanding", $time);
                end else begin
                    check_txn(out_txn, exp_q.pop_front(), "output");
                end
            end
            // Requests only for walks and in arrival order
            if (mem_req_o) begin
                if (req_q.size() == 0) begin
                    fault_cnt++;
                    $display("Memory request at %0t with no walk waiting", $time);
                end else begin
                    check_addr(mem_addr_o, req_q[0], "mem_addr_o");
                    if (mem_gnt_i) begin
                        void'(req_q.pop_front());
                    end
                end
            end
            if (in_valid_i && in_ready_o) begin
                exp_q.push_back(expect_txn(in_id_i, in_walk_i, in_addr_i));
                if (in_walk_i) begin
                    req_q.push_back(in_addr_i);
                end
                in_cnt++;
            end
            held     = out_valid_o && !out_ready_i;
            held_txn = out_txn;
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    // Starts and ends 2 ns after a rising edge
    task automatic send_txn(input logic walk, input mem_bus_pkg::mem_addr_t addr);
        in_valid_i = 1'b1;
        in_id_i    = next_id;
        in_walk_i  = walk;
        in_addr_i  = addr;
        next_id++;
        do begin
            @(posedge clk_i);
        end while (!in_ready_o);
        #2;
        in_valid_i = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    // Wait until every sent transaction has left and then a few quiet cycles
    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #2;
        idle_cycles(5);
        if (req_q.size() != 0) begin
            fault_cnt++;
            $display("%0d walks left without a memory request at %0t", req_q.size(), $time);
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_idle();
        repeat (4) begin
            @(negedge clk_i);
            check_bit(in_ready_o, 1'b1, "in_ready_o after reset");
            check_bit(out_valid_o, 1'b0, "out_valid_o after reset");
            check_bit(mem_req_o, 1'b0, "mem_req_o after reset");
        end
        @(posedge clk_i);
        #2;
    endtask

    task automatic test_single_walk();
        send_txn(1'b1, 32'h0001_2340);
        drain();
    endtask

    task automatic test_no_walk();
        for (int i = 0; i < 4; i++) begin
            send_txn(1'b0, $urandom());
        end
        drain();
    endtask

    task automatic test_mixed_stream();
        for (int i = 0; i < 40; i++) begin
            send_txn(1'($urandom_range(0, 1)), $urandom());
            idle_cycles(int'($urandom_range(0, 2)));
        end
        drain();
    endtask

    task automatic test_backpressure();
        int base;
        base = in_cnt;
        @(posedge clk_i);
        ready_mode = 1;
        #2;
        sender_busy = 1'b1;
        fork
            begin
                for (int i = 0; i < 10; i++) begin
                    send_txn(1'b1, $urandom());
                end
                sender_busy = 1'b0;
            end
        join_none
        repeat (30) @(posedge clk_i);
        @(negedge clk_i);
        // Full stage plus one item held in the input register
        check_count(stage_pkg::stage_cnt_t'(in_cnt - base),
                    stage_pkg::stage_cnt_t'(stage_pkg::STAGE_DEPTH + 1),
                    "transactions taken while stalled");
        check_bit(in_ready_o, 1'b0, "in_ready_o while stalled");
        @(posedge clk_i);
        ready_mode = 0;
        wait (!sender_busy);
        drain();
    endtask

    task automatic test_random_ready();
        @(posedge clk_i);
        ready_mode = 2;
        #2;
        for (int i = 0; i < 30; i++) begin
            send_txn(1'($urandom_range(0, 1)), $urandom());
            idle_cycles(int'($urandom_range(0, 2)));
        end
        drain();
        @(posedge clk_i);
        ready_mode = 0;
        #2;
    endtask

    ////////////////////////////////////////
    // Run control
    ////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        in_valid_i   = 1'b0;
        in_id_i      = '0;
        in_walk_i    = 1'b0;
        in_addr_i    = '0;
        out_ready_i  = 1'b1;
        ready_mode   = 0;
        next_id      = '0;
        held         = 1'b0;
        sender_busy  = 1'b0;
        mismatch_cnt = 0;
        fault_cnt    = 0;
        in_cnt       = 0;
        repeat (10) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        test_idle();
        test_single_walk();
        test_no_walk();
        test_mixed_stream();
        test_backpressure();
        test_random_ready();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fault_cnt);
        if (mismatch_cnt == 0 && fault_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Cycle limit against a hung handshake
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        fault_cnt++;
        $display("Timeout after %0d cycles with %0d transactions outstanding",
                 cycle_cnt, exp_q.size());
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fault_cnt);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== design/fifo_if.sv ====
////////////////////////////////////////
// FIFO port bundle
// Push, pop, data and status of one FIFO
////////////////////////////////////////

interface fifo_if #(
    parameter type elem_t = logic
);

    // Write side, driven by the controller
    logic                  push;
    elem_t                 wdata;

    // Read side
    logic                  pop;
    elem_t                 rdata;

    // Status, driven by the FIFO
    logic                  full;
    logic                  empty;
    stage_pkg::stage_cnt_t count;

    // Controller view
    modport ctrl (output push, wdata, pop, input rdata, full, empty, count);

    // FIFO view
    modport fifo (input push, wdata, pop, output rdata, full, empty, count);

endinterface

// ==== design/mem_bus_pkg.sv ====
////////////////////////////////////////
// Memory bus package
// Widths and vector types of the read-only memory port
////////////////////////////////////////

package mem_bus_pkg;

    // Address and data widths of the memory port
    localparam int unsigned MEM_ADDR_W = 32;
    localparam int unsigned MEM_DATA_W = 32;

    // Request address
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // Read data word
    typedef logic [MEM_DATA_W-1:0] mem_data_t;

endpackage

// ==== design/memory_read_stage.sv ====
////////////////////////////////////////
// Memory read stage
// Pipelined page-walk reads, in-order output
////////////////////////////////////////

module memory_read_stage (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Previous stage
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  stage_pkg::txn_id_t     in_id_i,
    input  logic                   in_walk_i,
    input  mem_bus_pkg::mem_addr_t in_addr_i,
    // Next stage
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output stage_pkg::txn_id_t     out_id_o,
    output logic                   out_walk_o,
    output mem_bus_pkg::mem_addr_t out_addr_o,
    output mem_bus_pkg::mem_data_t out_data_o,
    // Memory port
    output logic                   mem_req_o,
    output mem_bus_pkg::mem_addr_t mem_addr_o,
    input  logic                   mem_gnt_i,
    input  logic                   mem_rvalid_i,
    input  mem_bus_pkg::mem_data_t mem_rdata_i
);

    stage_pkg::txn_t in_txn;
    stage_pkg::txn_t reg_txn;
    stage_pkg::txn_t out_txn;
    logic            reg_valid;
    logic            reg_ready;

    // FIFO bundles
    fifo_if #(.elem_t(stage_pkg::txn_t))        gnt_if ();
    fifo_if #(.elem_t(mem_bus_pkg::mem_data_t)) rd_if ();
    fifo_if #(.elem_t(stage_pkg::txn_t))        out_if ();

    // Data field is filled later by the read
    assign in_txn.id   = in_id_i;
    assign in_txn.walk = in_walk_i;
    assign in_txn.addr = in_addr_i;
    assign in_txn.data = '0;

    req_register u_req_reg (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .s_valid_i (in_valid_i),
        .s_ready_o (in_ready_o),
        .s_txn_i   (in_txn),
        .m_valid_o (reg_valid),
        .m_ready_i (reg_ready),
        .m_txn_o   (reg_txn)
    );

    stage_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_valid_i  (reg_valid),
        .req_ready_o  (reg_ready),
        .req_txn_i    (reg_txn),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_gnt_i    (mem_gnt_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .gnt_f        (gnt_if),
        .rd_f         (rd_if),
        .out_f        (out_if),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_txn_o    (out_txn)
    );

    sync_fifo #(.elem_t(stage_pkg::txn_t)) grant_fifo_u (
        .clk_i (clk_i), .rst_ni (rst_ni), .f (gnt_if)
    );
    sync_fifo #(.elem_t(mem_bus_pkg::mem_data_t)) rdata_fifo_u (
        .clk_i (clk_i), .rst_ni (rst_ni), .f (rd_if)
    );
    sync_fifo #(.elem_t(stage_pkg::txn_t)) out_fifo_u (
        .clk_i (clk_i), .rst_ni (rst_ni), .f (out_if)
    );

    // Unpack the outgoing transaction
    assign out_id_o   = out_txn.id;
    assign out_walk_o = out_txn.walk;
    assign out_addr_o = out_txn.addr;
    assign out_data_o = out_txn.data;

endmodule

// ==== design/req_register.sv ====
////////////////////////////////////////
// Request register
// One valid/ready stage between the previous stage and the control
////////////////////////////////////////

module req_register (
    input  logic            clk_i,
    input  logic            rst_ni,

    // From previous stage
    input  logic            s_valid_i,
    output logic            s_ready_o,
    input  stage_pkg::txn_t s_txn_i,

    // To control
    output logic            m_valid_o,
    input  logic            m_ready_i,
    output stage_pkg::txn_t m_txn_o
);

    logic            valid_q;
    stage_pkg::txn_t txn_q;

    // Load when empty or when the held item leaves
    assign s_ready_o = !valid_q || m_ready_i;

    // Valid flag
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (s_ready_o) begin
            valid_q <= s_valid_i;
        end
    end

    // Payload, only on an accepted transfer
    always_ff @(posedge clk_i) begin
        if (s_valid_i && s_ready_o) begin
            txn_q <= s_txn_i;
        end
    end

    assign m_valid_o = valid_q;
    assign m_txn_o   = txn_q;

endmodule

// ==== design/stage_ctrl.sv ====
////////////////////////////////////////
// Read stage control
// Admission and memory request, data attach, ordered output
////////////////////////////////////////

module stage_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Registered request
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  stage_pkg::txn_t        req_txn_i,
    // Memory port
    output logic                   mem_req_o,
    output mem_bus_pkg::mem_addr_t mem_addr_o,
    input  logic                   mem_gnt_i,
    input  logic                   mem_rvalid_i,
    input  mem_bus_pkg::mem_data_t mem_rdata_i,
    // Grant, read data and output FIFOs
    fifo_if.ctrl                   gnt_f,
    fifo_if.ctrl                   rd_f,
    fifo_if.ctrl                   out_f,
    // Next stage
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output stage_pkg::txn_t        out_txn_o
);

    stage_pkg::grant_state_e gnt_state_q, gnt_state_d;
    stage_pkg::out_state_e   out_state_q, out_state_d;
    stage_pkg::stage_cnt_t   occupancy;
    logic                    has_room;
    logic                    last_slot;
    logic                    head_ready;
    stage_pkg::txn_t         head_txn;

    // Grant and output FIFOs together bound the stage
    assign occupancy = gnt_f.count + out_f.count;
    assign has_room  = (occupancy < stage_pkg::STAGE_CNT_MAX);
    assign last_slot = (occupancy == stage_pkg::STAGE_CNT_MAX - 1'b1);

    // Every returned word is kept, in request order
    assign rd_f.push  = mem_rvalid_i;
    assign rd_f.wdata = mem_rdata_i;

    ////////////////////////////////////////
    // Admission FSM
    ////////////////////////////////////////

    always_comb begin
        gnt_state_d = gnt_state_q;
        mem_req_o   = 1'b0;
        mem_addr_o  = '0;
        req_ready_o = 1'b0;
        gnt_f.push  = 1'b0;
        gnt_f.wdata = req_txn_i;
        case (gnt_state_q)
            stage_pkg::GNT_IDLE: begin
                if (req_valid_i && has_room) begin
                    // Walks go out on the memory port at once
                    if (req_txn_i.walk) begin
                        mem_req_o  = 1'b1;
                        mem_addr_o = req_txn_i.addr;
                    end
                    // gnt may already be high
                    if (!req_txn_i.walk || mem_gnt_i) begin
                        gnt_f.push  = 1'b1;
                        req_ready_o = 1'b1;
                        if (last_slot) begin
                            gnt_state_d = stage_pkg::GNT_WAIT_ROOM;
                        end
                    end else begin
                        gnt_state_d = stage_pkg::GNT_WAIT_GRANT;
                    end
                end
            end
            stage_pkg::GNT_WAIT_GRANT: begin
                // Hold the request, room was reserved on entry
                mem_req_o  = 1'b1;
                mem_addr_o = req_txn_i.addr;
                if (mem_gnt_i) begin
                    gnt_f.push  = 1'b1;
                    req_ready_o = 1'b1;
                    gnt_state_d = last_slot ? stage_pkg::GNT_WAIT_ROOM : stage_pkg::GNT_IDLE;
                end
            end
            stage_pkg::GNT_WAIT_ROOM: begin
                // No request until an item leaves
                if (has_room) begin
                    gnt_state_d = stage_pkg::GNT_IDLE;
                end
            end
            default: gnt_state_d = stage_pkg::GNT_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // Output FSM
    ////////////////////////////////////////

    // Walking head waits for its read word
    assign head_ready = !gnt_f.empty && (!gnt_f.rdata.walk || !rd_f.empty);

    always_comb begin
        head_txn      = gnt_f.rdata;
        head_txn.data = gnt_f.rdata.walk ? rd_f.rdata : '0;
    end

    always_comb begin
        out_state_d = out_state_q;
        gnt_f.pop   = 1'b0;
        rd_f.pop    = 1'b0;
        out_f.push  = 1'b0;
        out_f.pop   = 1'b0;
        out_f.wdata = head_txn;
        out_valid_o = 1'b0;
        out_txn_o   = head_txn;
        case (out_state_q)
            stage_pkg::OUT_IDLE: begin
                // Wake on the first admitted item
                if (gnt_f.push) begin
                    out_state_d = stage_pkg::OUT_PASS;
                end
            end
            stage_pkg::OUT_PASS: begin
                if (head_ready) begin
                    gnt_f.pop   = 1'b1;
                    rd_f.pop    = head_txn.walk;
                    out_valid_o = 1'b1;
                    // Not taken, so park it and keep it on the output
                    if (!out_ready_i) begin
                        out_f.push  = 1'b1;
                        out_state_d = stage_pkg::OUT_BUFFER;
                    end
                end else if (gnt_f.empty && !gnt_f.push) begin
                    out_state_d = stage_pkg::OUT_IDLE;
                end
            end
            stage_pkg::OUT_BUFFER: begin
                // Buffered items go first
                out_valid_o = !out_f.empty;
                out_txn_o   = out_f.rdata;
                out_f.pop   = out_ready_i && !out_f.empty;
                // Later heads queue behind them
                if (head_ready && !out_f.full) begin
                    gnt_f.pop  = 1'b1;
                    rd_f.pop   = head_txn.walk;
                    out_f.push = 1'b1;
                end
                if (out_f.pop && !out_f.push && out_f.count == stage_pkg::stage_cnt_t'(1)) begin
                    out_state_d = stage_pkg::OUT_PASS;
                end
            end
            default: out_state_d = stage_pkg::OUT_IDLE;
        endcase
    end

    // State registers
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            gnt_state_q <= stage_pkg::GNT_IDLE;
            out_state_q <= stage_pkg::OUT_IDLE;
        end else begin
            gnt_state_q <= gnt_state_d;
            out_state_q <= out_state_d;
        end
    end

endmodule

// ==== design/stage_pkg.sv ====
////////////////////////////////////////
// Read stage package
// Transaction, depth, counter and FSM state types
////////////////////////////////////////

package stage_pkg;

    // Most transactions held by the stage at once
    localparam int unsigned STAGE_DEPTH = 4;
    localparam int unsigned TXN_ID_W    = 4;
    localparam int unsigned STAGE_PTR_W = $clog2(STAGE_DEPTH);

    typedef logic [TXN_ID_W-1:0]               txn_id_t;
    // Occupancy from zero up to STAGE_DEPTH included
    typedef logic [$clog2(STAGE_DEPTH+1)-1:0]  stage_cnt_t;
    typedef logic [STAGE_PTR_W-1:0]            stage_ptr_t;

    // Occupancy of a full stage
    localparam stage_cnt_t STAGE_CNT_MAX = stage_cnt_t'(STAGE_DEPTH);

    // Transaction carried through the stage
    typedef struct packed {
        txn_id_t                id;
        logic                   walk;
        mem_bus_pkg::mem_addr_t addr;
        mem_bus_pkg::mem_data_t data;
    } txn_t;

    typedef enum logic [1:0] {GNT_IDLE, GNT_WAIT_GRANT, GNT_WAIT_ROOM} grant_state_e;
    typedef enum logic [1:0] {OUT_IDLE, OUT_PASS, OUT_BUFFER} out_state_e;

endpackage

// ==== design/sync_fifo.sv ====
////////////////////////////////////////
// Synchronous FIFO
// STAGE_DEPTH entries, head served without fall-through
////////////////////////////////////////

module sync_fifo #(
    parameter type elem_t = logic
) (
    input  logic clk_i,
    input  logic rst_ni,
    fifo_if.fifo f
);

    // Storage and pointers
    elem_t                 mem_q [stage_pkg::STAGE_DEPTH];
    stage_pkg::stage_ptr_t wr_ptr_q;
    stage_pkg::stage_ptr_t rd_ptr_q;
    stage_pkg::stage_cnt_t cnt_q;
    logic                  do_push;
    logic                  do_pop;

    // Ignore push when full and pop when empty
    assign do_push = f.push && (cnt_q != stage_pkg::STAGE_CNT_MAX);
    assign do_pop  = f.pop && (cnt_q != '0);

    ////////////////////////////////////////
    // Pointers and count
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (do_push) begin
                // Wrap at the last entry
                if (wr_ptr_q == stage_pkg::stage_ptr_t'(stage_pkg::STAGE_DEPTH - 1)) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr_q == stage_pkg::stage_ptr_t'(stage_pkg::STAGE_DEPTH - 1)) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
            // Push and pop together keep the count
            if (do_push && !do_pop) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (do_pop && !do_push) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // Entry write
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= f.wdata;
        end
    end

    // Head and status
    assign f.rdata = mem_q[rd_ptr_q];
    assign f.full  = (cnt_q == stage_pkg::STAGE_CNT_MAX);
    assign f.empty = (cnt_q == '0);
    assign f.count = cnt_q;

endmodule

// ==== list.f ====
design/mem_bus_pkg.sv
design/stage_pkg.sv
design/fifo_if.sv
design/sync_fifo.sv
design/req_register.sv
design/stage_ctrl.sv
design/memory_read_stage.sv
bench/mem_model.sv
bench/tb_top.sv
